// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// instruction word and address widths
`define INSTR_WIDTH 32
`define ADDR_WIDTH 32

// pc step between consecutive instructions
`define INSTR_BYTES 4

// register file has 16 entries
`define REG_INDEX_WIDTH 4

// instruction field widths
`define GROUP_WIDTH 2
`define OPER_WIDTH 4
`define IMM12_WIDTH 12
`define IMM20_WIDTH 20

// number of defined operations in each group
// anything at or above the count is decoded as a nop
`define NUM_OPERS_ALU 15
`define NUM_OPERS_BRANCH 3
`define NUM_OPERS_LOAD 9
`define NUM_OPERS_STORE 9

// spare bits left over in each instruction format
`define REG_FMT_SPARE_WIDTH (`INSTR_WIDTH - `GROUP_WIDTH - `OPER_WIDTH - 1 \
	- 3 * `REG_INDEX_WIDTH - `IMM12_WIDTH)
`define BRANCH_FMT_SPARE_WIDTH (`INSTR_WIDTH - `GROUP_WIDTH - `OPER_WIDTH - 1 \
	- `REG_INDEX_WIDTH - `IMM20_WIDTH)

`endif

// File: cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`REG_INDEX_WIDTH-1:0] reg_index_t;

	typedef enum logic [`GROUP_WIDTH-1:0]
	{
		group_alu,
		group_branch,
		group_load,
		group_store
	} instr_group_e;

	// three-register layout used by alu, load and store
	typedef struct packed
	{
		instr_group_e group;
		logic [`OPER_WIDTH-1:0] oper;
		logic op_type;
		reg_index_t ra;
		reg_index_t rb;
		reg_index_t rc;
		logic [`REG_FMT_SPARE_WIDTH-1:0] unused;
		logic [`IMM12_WIDTH-1:0] imm12;
	} reg_fmt_s;

	// branch layout, one register and a long immediate
	typedef struct packed
	{
		instr_group_e group;
		logic [`OPER_WIDTH-1:0] oper;
		logic op_type;
		reg_index_t ra;
		logic [`BRANCH_FMT_SPARE_WIDTH-1:0] unused;
		logic [`IMM20_WIDTH-1:0] imm20;
	} branch_fmt_s;

	// group, oper, op_type and ra sit at the same bits in both views
	typedef union packed
	{
		reg_fmt_s reg_fmt;
		branch_fmt_s branch_fmt;
	} instr_word_u;

	typedef struct packed
	{
		instr_group_e group;
		logic [`OPER_WIDTH-1:0] oper;
		logic op_type;
		reg_index_t ra;
		reg_index_t rb;
		reg_index_t rc;
		addr_t signext_imm;
		logic nop;
	} decoded_instr_s;

	typedef struct packed
	{
		logic req;
		addr_t addr;
	} cache_req_s;

	typedef struct packed
	{
		logic valid;
		instr_word_u instr;
	} cache_resp_s;

	typedef struct packed
	{
		logic stall;
		addr_t computed_pc;
	} from_ex_s;

	typedef struct packed
	{
		decoded_instr_s decoded_instr;
		addr_t pc_val;
	} to_ex_s;

	typedef struct packed
	{
		reg_index_t ra;
		reg_index_t rb;
		reg_index_t rc;
	} reg_indices_s;

endpackage

// File: fetch_decode_stage.f
+incdir+.
cpu_pkg.sv
instr_decoder.sv
fetch_sequencer.sv
fetch_decode_stage.sv
tb_fetch_decode_stage.sv

// File: fetch_decode_stage.sv
module fetch_decode_stage
	import cpu_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	output cache_req_s   cache_req,
	input  cache_resp_s  cache_resp,
	input  from_ex_s     from_ex,
	input  logic         wb_stall,
	output to_ex_s       to_ex,
	output reg_indices_s reg_indices
);

	decoded_instr_s decoded;

	// decode whatever the cache presents, valid or not
	instr_decoder u_decoder
	(
		.instr   (cache_resp.instr),
		.decoded (decoded)
	);

	fetch_sequencer u_sequencer
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.decoded     (decoded),
		.cache_valid (cache_resp.valid),
		.from_ex     (from_ex),
		.wb_stall    (wb_stall),
		.cache_req   (cache_req),
		.to_ex       (to_ex),
		.reg_indices (reg_indices)
	);

endmodule

// File: fetch_sequencer.sv
`include "cpu_macros.svh"

module fetch_sequencer
	import cpu_pkg::*;
(
	input  logic           clk,
	input  logic           arst_n,
	input  decoded_instr_s decoded,
	input  logic           cache_valid,
	input  from_ex_s       from_ex,
	input  logic           wb_stall,
	output cache_req_s     cache_req,
	output to_ex_s         to_ex,
	output reg_indices_s   reg_indices
);

	typedef enum logic [2:0]
	{
		st_init,
		st_regular,
		st_change_pc,
		st_ldst_wait0,
		st_ldst_wait1
	} fetch_state_e;

	// empty slot sent to execute
	localparam decoded_instr_s bubble_instr = '{
		group: group_alu,
		oper: '0,
		op_type: 1'b0,
		ra: '0,
		rb: '0,
		rc: '0,
		signext_imm: '0,
		nop: 1'b1
	};

	fetch_state_e state;
	addr_t pc;
	addr_t following_pc;
	logic advance;
	logic takes_branch;

	assign following_pc = pc + addr_t'(`INSTR_BYTES);

	// a fresh word is consumed only when execute can take it
	assign advance = cache_valid && !from_ex.stall;
	assign takes_branch = (decoded.group == group_branch) && !decoded.nop;

	always_comb
	begin
		cache_req.req = 1'b1;
		cache_req.addr = pc;

		if (state == st_regular && advance)
		begin
			cache_req.addr = following_pc;
			// no fetch while the branch target is still unknown
			if (takes_branch)
			begin
				cache_req.req = 1'b0;
			end
		end
		else if (state == st_change_pc)
		begin
			cache_req.addr = from_ex.computed_pc;
		end
	end

	always_comb
	begin
		reg_indices = '0;
		if (state == st_regular)
		begin
			reg_indices.ra = decoded.ra;
			reg_indices.rb = decoded.rb;
			reg_indices.rc = decoded.rc;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= st_init;
			pc <= '0;
			to_ex.decoded_instr <= bubble_instr;
			to_ex.pc_val <= '0;
		end
		else
		begin
			case (state)
				st_init:
				begin
					// first word arrives, pc stays on it
					if (cache_valid)
					begin
						state <= st_regular;
					end
					to_ex.decoded_instr <= bubble_instr;
				end
				st_regular:
				begin
					// a stall from execute holds to_ex as it is
					if (!cache_valid && !from_ex.stall)
					begin
						to_ex.decoded_instr <= bubble_instr;
					end
					else if (advance)
					begin
						pc <= following_pc;
						if (decoded.nop)
						begin
							to_ex.decoded_instr <= bubble_instr;
						end
						else
						begin
							to_ex.decoded_instr <= decoded;
							to_ex.pc_val <= pc;
							case (decoded.group)
								group_branch:
								begin
									// execute computes the target from the return pc
									to_ex.pc_val <= following_pc;
									state <= st_change_pc;
								end
								group_load, group_store:
								begin
									state <= st_ldst_wait0;
								end
								default:
								begin
									state <= st_regular;
								end
							endcase
						end
					end
				end
				st_change_pc:
				begin
					pc <= from_ex.computed_pc;
					state <= st_regular;
					to_ex.decoded_instr <= bubble_instr;
				end
				st_ldst_wait0:
				begin
					state <= st_ldst_wait1;
					to_ex.decoded_instr <= bubble_instr;
				end
				st_ldst_wait1:
				begin
					// writeback finished
					if (!wb_stall)
					begin
						state <= st_regular;
					end
					to_ex.decoded_instr <= bubble_instr;
				end
				default:
				begin
					state <= st_init;
				end
			endcase
		end
	end

endmodule

// File: instr_decoder.sv
`include "cpu_macros.svh"

module instr_decoder
	import cpu_pkg::*;
(
	input  instr_word_u    instr,
	output decoded_instr_s decoded
);

	localparam int count_width = `OPER_WIDTH + 1;
	localparam int imm12_pad = `ADDR_WIDTH - `IMM12_WIDTH;
	localparam int imm20_pad = `ADDR_WIDTH - `IMM20_WIDTH;

	logic is_branch;
	logic [count_width-1:0] oper_count;
	addr_t imm12_ext;
	addr_t imm20_ext;

	// group bits are shared by both views so either one selects the format
	assign is_branch = (instr.reg_fmt.group == group_branch);

	assign imm12_ext = {{imm12_pad{instr.reg_fmt.imm12[`IMM12_WIDTH-1]}},
		instr.reg_fmt.imm12};
	assign imm20_ext = {{imm20_pad{instr.branch_fmt.imm20[`IMM20_WIDTH-1]}},
		instr.branch_fmt.imm20};

	// how many opers each group defines
	always_comb
	begin
		case (instr.reg_fmt.group)
			group_alu:
			begin
				oper_count = count_width'(`NUM_OPERS_ALU);
			end
			group_branch:
			begin
				oper_count = count_width'(`NUM_OPERS_BRANCH);
			end
			group_load:
			begin
				oper_count = count_width'(`NUM_OPERS_LOAD);
			end
			group_store:
			begin
				oper_count = count_width'(`NUM_OPERS_STORE);
			end
		endcase
	end

	always_comb
	begin
		decoded.group = instr.reg_fmt.group;
		// oper, op_type and ra sit at the same bits in both formats
		decoded.oper = instr.reg_fmt.oper;
		decoded.op_type = instr.reg_fmt.op_type;
		decoded.ra = instr.reg_fmt.ra;

		if (is_branch)
		begin
			// branches carry no second or third register
			decoded.rb = '0;
			decoded.rc = '0;
			decoded.signext_imm = imm20_ext;
		end
		else
		begin
			decoded.rb = instr.reg_fmt.rb;
			decoded.rc = instr.reg_fmt.rc;
			decoded.signext_imm = imm12_ext;
		end

		// undefined oper for this group
		decoded.nop = ({1'b0, instr.reg_fmt.oper} >= oper_count);
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the fetch and decode stage testbench with Verilator

build_dir=obj_dir
log_file=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_fetch_decode_stage \
	--Mdir "$build_dir" \
	-f fetch_decode_stage.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./"$build_dir"/Vtb_fetch_decode_stage > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" "$log_file"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: tb_fetch_decode_stage.sv
`include "cpu_macros.svh"

module tb_fetch_decode_stage
	import cpu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 10;
	localparam int num_words = 256;
	localparam int num_issues = 256;
	localparam int cycles_per_issue = 12;
	// program space repeats every 1 KiB
	localparam addr_t wrap_mask = 32'h0000_03ff;

	logic clk = 1'b0;
	logic arst_n;
	cache_req_s cache_req;
	cache_resp_s cache_resp;
	from_ex_s from_ex;
	logic wb_stall;
	to_ex_s to_ex;
	reg_indices_s reg_indices;

	logic [`INSTR_WIDTH-1:0] program_mem [num_words];
	logic [31:0] rng_state;
	int wb_cycles;

	// what the DUT saw on the last rising edge
	logic run_q;
	cache_req_s req_q;
	reg_indices_s indices_q;
	logic stall_q;
	logic wb_stall_q;

	addr_t walk_pc;
	to_ex_s prev_to_ex;
	int issued = 0;
	int decode_errors = 0;
	int addr_errors = 0;
	int index_errors = 0;
	int other_errors = 0;

	fetch_decode_stage u_dut
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.cache_req   (cache_req),
		.cache_resp  (cache_resp),
		.from_ex     (from_ex),
		.wb_stall    (wb_stall),
		.to_ex       (to_ex),
		.reg_indices (reg_indices)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected decode, straight from the bit positions of the encoding
	function automatic decoded_instr_s ref_decode(input logic [`INSTR_WIDTH-1:0] word);
		decoded_instr_s d;
		int defined_opers;
		defined_opers = 0;
		d.group = instr_group_e'(word[31:30]);
		d.oper = word[29:26];
		d.op_type = word[25];
		d.ra = word[24:21];
		if (d.group == group_branch)
		begin
			d.rb = '0;
			d.rc = '0;
			d.signext_imm = {{12{word[19]}}, word[19:0]};
		end
		else
		begin
			d.rb = word[20:17];
			d.rc = word[16:13];
			d.signext_imm = {{20{word[11]}}, word[11:0]};
		end
		case (d.group)
			group_alu: defined_opers = `NUM_OPERS_ALU;
			group_branch: defined_opers = `NUM_OPERS_BRANCH;
			group_load: defined_opers = `NUM_OPERS_LOAD;
			group_store: defined_opers = `NUM_OPERS_STORE;
		endcase
		d.nop = (int'(d.oper) >= defined_opers);
		return d;
	endfunction

	function automatic decoded_instr_s expected_bubble();
		decoded_instr_s d;
		d = '0;
		d.nop = 1'b1;
		return d;
	endfunction

	// next instruction in program order, undefined opers skipped
	task automatic walk_next(output addr_t exp_pc, output decoded_instr_s exp_dec);
		decoded_instr_s d;
		int steps;
		steps = 0;
		d = ref_decode(program_mem[walk_pc[9:2]]);
		while (d.nop && steps < num_words)
		begin
			walk_pc = walk_pc + 32'd4;
			d = ref_decode(program_mem[walk_pc[9:2]]);
			steps++;
		end
		exp_dec = d;
		if (d.group == group_branch)
		begin
			exp_pc = walk_pc + 32'd4;
			walk_pc = (exp_pc + (d.signext_imm << 2)) & wrap_mask;
		end
		else
		begin
			exp_pc = walk_pc;
			walk_pc = walk_pc + 32'd4;
		end
	endtask

	task automatic fill_program();
		logic [31:0] word;
		logic [19:0] offset;
		for (int i = 0; i < num_words; i++)
		begin
			rng_state = lcg_step(rng_state);
			word = rng_state;
			// short jumps, mostly forward and never onto the branch itself
			if (word[31:30] == 2'd1)
			begin
				rng_state = lcg_step(rng_state);
				offset = 20'(int'(rng_state[27:24]) - 4);
				if (offset == 20'hfffff)
				begin
					offset = 20'h00000;
				end
				word[19:0] = offset;
			end
			program_mem[i] = word;
		end
	endtask

	task automatic check_decoded(input string name, input decoded_instr_s actual,
		input decoded_instr_s expected);
		if (actual !== expected)
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			decode_errors++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
		if (actual !== expected)
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			addr_errors++;
		end
	endtask

	task automatic check_indices(input string name, input reg_indices_s actual,
		input reg_indices_s expected);
		if (actual !== expected)
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			index_errors++;
		end
	endtask

	always @(posedge clk)
	begin
		run_q <= arst_n;
		req_q <= cache_req;
		indices_q <= reg_indices;
		stall_q <= from_ex.stall;
		wb_stall_q <= wb_stall;
	end

	// program fill, then cache, execute and writeback models
	initial
	begin
		cache_resp = '0;
		from_ex = '0;
		wb_stall = 1'b0;
		wb_cycles = 0;
		rng_state = 32'd13;
		fill_program();
		forever
		begin
			@(negedge clk);
			// answer to the request taken on the last rising edge
			cache_resp.valid = req_q.req;
			cache_resp.instr = program_mem[req_q.addr[9:2]];
			from_ex.computed_pc = (to_ex.pc_val + (to_ex.decoded_instr.signext_imm << 2))
				& wrap_mask;
			rng_state = lcg_step(rng_state);
			from_ex.stall = (rng_state[31:30] == 2'b00);
			// writeback stays busy a few cycles after a fresh load or store
			if (!stall_q && !to_ex.decoded_instr.nop
				&& (to_ex.decoded_instr.group == group_load
				|| to_ex.decoded_instr.group == group_store))
			begin
				rng_state = lcg_step(rng_state);
				wb_cycles = int'(rng_state[29:28]);
			end
			wb_stall = (wb_cycles > 0);
			if (wb_cycles > 0)
			begin
				wb_cycles--;
			end
		end
	end

	always @(negedge clk)
	begin
		addr_t exp_pc;
		decoded_instr_s exp_dec;
		reg_indices_s exp_indices;
		if (!run_q)
		begin
			walk_pc = '0;
		end
		else if (stall_q && (prev_to_ex.decoded_instr.nop
			|| prev_to_ex.decoded_instr.group == group_alu))
		begin
			// back-pressure holds the issue register
			check_decoded("to_ex.decoded_instr", to_ex.decoded_instr, prev_to_ex.decoded_instr);
			check_addr("to_ex.pc_val", to_ex.pc_val, prev_to_ex.pc_val);
		end
		else if (to_ex.decoded_instr.nop)
		begin
			check_decoded("to_ex.decoded_instr", to_ex.decoded_instr, expected_bubble());
		end
		else if (!stall_q)
		begin
			walk_next(exp_pc, exp_dec);
			check_decoded("to_ex.decoded_instr", to_ex.decoded_instr, exp_dec);
			check_addr("to_ex.pc_val", to_ex.pc_val, exp_pc);
			if (exp_dec.group == group_branch)
			begin
				if (req_q.req)
				begin
					$display("Error at %0t: cache request was high while a branch issued", $time);
					other_errors++;
				end
			end
			else
			begin
				exp_indices.ra = exp_dec.ra;
				exp_indices.rb = exp_dec.rb;
				exp_indices.rc = exp_dec.rc;
				check_indices("reg_indices", indices_q, exp_indices);
			end
			if (wb_stall_q)
			begin
				$display("Error at %0t: an instruction issued while writeback stalled", $time);
				other_errors++;
			end
			issued++;
		end
		else
		begin
			$display("Error at %0t: a new instruction issued while execute stalled", $time);
			other_errors++;
		end
		prev_to_ex = to_ex;
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		while (issued < num_issues)
		begin
			@(negedge clk);
		end
		@(negedge clk);
		$display("issued %0d, decode errors %0d, address errors %0d, index errors %0d, other %0d",
			issued, decode_errors, addr_errors, index_errors, other_errors);
		if (decode_errors + addr_errors + index_errors + other_errors == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// generous bound on cycles per issued instruction
	initial
	begin
		#(num_issues * cycles_per_issue * clk_period);
		$display("Timeout: only %0d of %0d instructions were issued", issued, num_issues);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule
